// ==== flist.f ====
+incdir+source
source/zipdbg_pkg.sv
source/dbg_skidbuffer.sv
source/dbg_decode.sv
source/dbg_control.sv
source/dbg_response.sv
source/zipaxi_dbg.sv
sim/tb_cpu_model.sv
sim/tb_zipaxi_dbg.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the debug slave testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/100ps \
	--top-module tb_zipaxi_dbg \
	-f flist.f \
	-Mdir build/obj -o sim_tb

./build/obj/sim_tb | tee build/sim.log

if grep -q "Test failures found" build/sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "All tests passed!" build/sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

// ==== sim/tb_zipaxi_dbg.sv ====
// Testbench for the AXI-lite debug slave with AXI-lite driver tasks, compare tasks and directed tests
`include "zipdbg_defines.svh"

module tb_zipaxi_dbg;
	timeunit 1ns;
	timeprecision 100ps;
	import zipdbg_pkg::*;

	localparam int         TIMEOUT     = 200;
	localparam logic [7:0] STATUS_ADDR = 8'h00;

	// Clock and reset
	logic                      S_AXI_ACLK = 1'b0;
	logic                      S_AXI_ARESETN;
	// AXI-lite master side
	logic                      S_AXI_AWVALID;
	logic                      S_AXI_AWREADY;
	logic [`ZDBG_ADDR_W-1:0]   S_AXI_AWADDR;
	logic [2:0]                S_AXI_AWPROT;
	logic                      S_AXI_WVALID;
	logic                      S_AXI_WREADY;
	logic [`ZDBG_DATA_W-1:0]   S_AXI_WDATA;
	logic [`ZDBG_DATA_W/8-1:0] S_AXI_WSTRB;
	logic                      S_AXI_BVALID;
	logic                      S_AXI_BREADY;
	logic [1:0]                S_AXI_BRESP;
	logic                      S_AXI_ARVALID;
	logic                      S_AXI_ARREADY;
	logic [`ZDBG_ADDR_W-1:0]   S_AXI_ARADDR;
	logic [2:0]                S_AXI_ARPROT;
	logic                      S_AXI_RVALID;
	logic                      S_AXI_RREADY;
	logic [`ZDBG_DATA_W-1:0]   S_AXI_RDATA;
	logic [1:0]                S_AXI_RRESP;
	// Side band and CPU port
	logic                      interrupt;
	logic                      cpu_reset;
	dbg_cpu_ctl_t              cpu_ctl;
	dbg_cpu_stat_t             cpu_stat;
	logic                      cmd_reset;
	logic                      halted;
	logic                      brk_req;
	logic [2:0]                cc_in;

	// Bookkeeping
	int          test_errs;
	int          run_tests;
	int          fail_tests;
	int          run_cycles;
	int          clear_cycles;
	logic [31:0] rng_state = 32'h0cc96fd0;

	always #4 S_AXI_ACLK = !S_AXI_ACLK;

	zipaxi_dbg i_zipaxi_dbg (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_interrupt  (interrupt),
		.i_cpu_reset  (cpu_reset),
		.S_AXI_AWVALID(S_AXI_AWVALID),
		.S_AXI_AWREADY(S_AXI_AWREADY),
		.S_AXI_AWADDR (S_AXI_AWADDR),
		.S_AXI_AWPROT (S_AXI_AWPROT),
		.S_AXI_WVALID (S_AXI_WVALID),
		.S_AXI_WREADY (S_AXI_WREADY),
		.S_AXI_WDATA  (S_AXI_WDATA),
		.S_AXI_WSTRB  (S_AXI_WSTRB),
		.S_AXI_BVALID (S_AXI_BVALID),
		.S_AXI_BREADY (S_AXI_BREADY),
		.S_AXI_BRESP  (S_AXI_BRESP),
		.S_AXI_ARVALID(S_AXI_ARVALID),
		.S_AXI_ARREADY(S_AXI_ARREADY),
		.S_AXI_ARADDR (S_AXI_ARADDR),
		.S_AXI_ARPROT (S_AXI_ARPROT),
		.S_AXI_RVALID (S_AXI_RVALID),
		.S_AXI_RREADY (S_AXI_RREADY),
		.S_AXI_RDATA  (S_AXI_RDATA),
		.S_AXI_RRESP  (S_AXI_RRESP),
		.o_cpu_ctl    (cpu_ctl),
		.i_cpu_stat   (cpu_stat),
		.o_cmd_reset  (cmd_reset),
		.o_halted     (halted)
	);

	tb_cpu_model u_cpu (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_ctl        (cpu_ctl),
		.o_stat       (cpu_stat),
		.i_brk_req    (brk_req),
		.i_cc         (cc_in)
	);

	// Cycles the CPU ran and cycles clear_cache was up
	always @(negedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN)
		begin
			if (!halted)
				run_cycles <= run_cycles + 1;
			if (cpu_ctl.clear_cache)
				clear_cycles <= clear_cycles + 1;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Byte address 0x80 and up is register space
	function automatic logic [7:0] reg_addr(input logic [4:0] idx);
		return {1'b1, idx, 2'b00};
	endfunction

	// Expected status word, bit by bit
	function automatic dbg_status_t status_word(input logic halt, input logic run_done,
			input logic brk, input logic [2:0] cc);
		logic [31:0] w;
		w        = '0;
		w[6]     = 1'b0;
		w[7]     = 1'b0;
		w[9]     = run_done;
		w[10]    = halt;
		w[14:12] = cc;
		w[15]    = brk;
		w[16]    = 1'b0;
		return dbg_status_t'(w);
	endfunction

	task automatic check_status(input string name, input dbg_status_t exp,
			input dbg_status_t act);
		if (exp !== act)
		begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act)
		begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic report_error(input string name, input string what);
		$display("%s: %s", name, what);
		test_errs++;
	endtask

	task automatic start_test();
		test_errs = 0;
		run_tests++;
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0)
			$display("%s: ok", name);
		else
		begin
			$display("%s: %0d check(s) went wrong", name, test_errs);
			fail_tests++;
		end
	endtask

	//////////////////////////////
	// AXI-lite driver tasks
	//////////////////////////////

	// AW and W together, then wait for BVALID
	task automatic write_word(input string name, input logic [7:0] addr,
			input logic [31:0] data, input logic [3:0] strb);
		bit aw_done;
		bit w_done;
		bit aw_hit;
		bit w_hit;
		int guard;
		aw_done = 1'b0;
		w_done  = 1'b0;
		guard   = 0;
		@(posedge S_AXI_ACLK);
		S_AXI_AWVALID <= 1'b1;
		S_AXI_AWADDR  <= addr;
		S_AXI_WVALID  <= 1'b1;
		S_AXI_WDATA   <= data;
		S_AXI_WSTRB   <= strb;
		while (!(aw_done && w_done) && guard < TIMEOUT)
		begin
			// Ready is stable mid cycle
			@(negedge S_AXI_ACLK);
			aw_hit = S_AXI_AWVALID && S_AXI_AWREADY;
			w_hit  = S_AXI_WVALID && S_AXI_WREADY;
			@(posedge S_AXI_ACLK);
			if (aw_hit)
			begin
				aw_done = 1'b1;
				S_AXI_AWVALID <= 1'b0;
			end
			if (w_hit)
			begin
				w_done = 1'b1;
				S_AXI_WVALID <= 1'b0;
			end
			guard++;
		end
		if (!(aw_done && w_done))
		begin
			report_error(name, "timed out, write address or data was never accepted");
			S_AXI_AWVALID <= 1'b0;
			S_AXI_WVALID  <= 1'b0;
		end
		else
		begin
			guard = 0;
			@(negedge S_AXI_ACLK);
			while (!S_AXI_BVALID && guard < TIMEOUT)
			begin
				@(negedge S_AXI_ACLK);
				guard++;
			end
			if (!S_AXI_BVALID)
				report_error(name, "timed out, no write response came back");
			else
				check_word(name, 32'h0, 32'(S_AXI_BRESP));
		end
	endtask

	// Optional RREADY back-pressure for hold cycles, RDATA must not move
	task automatic read_word(input string name, input logic [7:0] addr, input int hold,
			output logic [31:0] data);
		bit done;
		bit hit;
		int guard;
		done  = 1'b0;
		guard = 0;
		data  = '0;
		@(posedge S_AXI_ACLK);
		S_AXI_ARVALID <= 1'b1;
		S_AXI_ARADDR  <= addr;
		if (hold > 0)
			S_AXI_RREADY <= 1'b0;
		while (!done && guard < TIMEOUT)
		begin
			@(negedge S_AXI_ACLK);
			hit = S_AXI_ARVALID && S_AXI_ARREADY;
			@(posedge S_AXI_ACLK);
			if (hit)
			begin
				done = 1'b1;
				S_AXI_ARVALID <= 1'b0;
			end
			guard++;
		end
		if (!done)
		begin
			report_error(name, "timed out, read address was never accepted");
			S_AXI_ARVALID <= 1'b0;
			S_AXI_RREADY  <= 1'b1;
		end
		else
		begin
			guard = 0;
			@(negedge S_AXI_ACLK);
			while (!S_AXI_RVALID && guard < TIMEOUT)
			begin
				@(negedge S_AXI_ACLK);
				guard++;
			end
			if (!S_AXI_RVALID)
				report_error(name, "timed out, read data never became valid");
			else
			begin
				data = S_AXI_RDATA;
				check_word(name, 32'h0, 32'(S_AXI_RRESP));
				// Beat parked while RREADY is low
				repeat (hold)
				begin
					@(negedge S_AXI_ACLK);
					if (!S_AXI_RVALID)
						report_error(name, "read data valid dropped while RREADY was low");
					check_word(name, data, S_AXI_RDATA);
				end
			end
			if (hold > 0)
			begin
				@(posedge S_AXI_ACLK);
				S_AXI_RREADY <= 1'b1;
				@(posedge S_AXI_ACLK);
			end
		end
	endtask

	// Halted means halt commanded and CPU quiet, running means stalled
	task automatic wait_cpu(input string name, input bit want_halted);
		int guard;
		guard = 0;
		@(negedge S_AXI_ACLK);
		while ((want_halted ? !(cpu_ctl.halt && halted) : halted) && guard < TIMEOUT)
		begin
			@(negedge S_AXI_ACLK);
			guard++;
		end
		if (want_halted && !(cpu_ctl.halt && halted))
			report_error(name, "timed out, CPU never halted");
		else if (!want_halted && halted)
			report_error(name, "timed out, CPU never started running");
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	// Starts right on the reset release edge
	task automatic reset_hold();
		logic [31:0] rd;
		int          count;
		int          guard;
		start_test();
		count = 0;
		guard = 0;
		@(negedge S_AXI_ACLK);
		while (cmd_reset && guard < TIMEOUT)
		begin
			count++;
			@(negedge S_AXI_ACLK);
			guard++;
		end
		if (cmd_reset)
			report_error("reset_hold", "timed out, CPU reset never released");
		else
			check_word("reset_hold", `ZDBG_RESET_HOLD, count);
		read_word("reset_hold", STATUS_ADDR, 0, rd);
		check_status("reset_hold", status_word(1'b1, 1'b1, 1'b0, 3'b000), dbg_status_t'(rd));
		finish_test("reset_hold");
	endtask

	task automatic reg_roundtrip();
		logic [31:0] exp [0:7];
		logic [31:0] rd;
		start_test();
		for (int i = 0; i < 8; i++)
		begin
			exp[i] = next_random();
			write_word("reg_roundtrip", reg_addr(5'(2 + 3 * i)), exp[i], 4'hf);
		end
		for (int i = 0; i < 8; i++)
		begin
			read_word("reg_roundtrip", reg_addr(5'(2 + 3 * i)), 0, rd);
			check_word("reg_roundtrip", exp[i], rd);
		end
		finish_test("reg_roundtrip");
	endtask

	task automatic halt_release();
		logic [31:0] rd;
		start_test();
		// Byte 1 only, halt clear
		write_word("halt_release", STATUS_ADDR, 32'h0, 4'b0010);
		wait_cpu("halt_release", 1'b0);
		read_word("halt_release", STATUS_ADDR, 0, rd);
		check_status("halt_release", status_word(1'b0, 1'b0, 1'b0, 3'b000),
				dbg_status_t'(rd));
		write_word("halt_release", STATUS_ADDR, 32'h1 << `ZDBG_HALT_BIT, 4'b0010);
		wait_cpu("halt_release", 1'b1);
		read_word("halt_release", STATUS_ADDR, 0, rd);
		check_status("halt_release", status_word(1'b1, 1'b1, 1'b0, 3'b000),
				dbg_status_t'(rd));
		finish_test("halt_release");
	endtask

	task automatic step_and_clear();
		logic [31:0] rd;
		int          run0;
		int          clr0;
		start_test();
		run0 = run_cycles;
		clr0 = clear_cycles;
		// One step is one run cycle
		write_word("step_and_clear", STATUS_ADDR, 32'h1 << `ZDBG_STEP_BIT, 4'b0010);
		wait_cpu("step_and_clear", 1'b1);
		read_word("step_and_clear", STATUS_ADDR, 0, rd);
		check_status("step_and_clear", status_word(1'b1, 1'b1, 1'b0, 3'b000),
				dbg_status_t'(rd));
		check_word("step_and_clear", 32'd1, 32'(run_cycles - run0));
		// Clear cache with halt, CPU stays put
		write_word("step_and_clear", STATUS_ADDR,
				(32'h1 << `ZDBG_CLEAR_BIT) | (32'h1 << `ZDBG_HALT_BIT), 4'b0010);
		wait_cpu("step_and_clear", 1'b1);
		read_word("step_and_clear", STATUS_ADDR, 0, rd);
		check_status("step_and_clear", status_word(1'b1, 1'b1, 1'b0, 3'b000),
				dbg_status_t'(rd));
		check_word("step_and_clear", 32'd1, 32'(clear_cycles - clr0));
		check_word("step_and_clear", 32'd1, 32'(run_cycles - run0));
		finish_test("step_and_clear");
	endtask

	task automatic break_backpressure();
		logic [31:0] rd;
		start_test();
		write_word("break_backpressure", STATUS_ADDR, 32'h0, 4'b0010);
		wait_cpu("break_backpressure", 1'b0);
		@(posedge S_AXI_ACLK);
		brk_req <= 1'b1;
		cc_in   <= 3'b101;
		@(posedge S_AXI_ACLK);
		brk_req <= 1'b0;
		wait_cpu("break_backpressure", 1'b1);
		// Status beat held back four cycles
		read_word("break_backpressure", STATUS_ADDR, 4, rd);
		check_status("break_backpressure", status_word(1'b1, 1'b1, 1'b1, 3'b101),
				dbg_status_t'(rd));
		finish_test("break_backpressure");
	endtask

	//////////////////////////////
	// Sequence
	//////////////////////////////

	initial
	begin
		S_AXI_ARESETN <= 1'b0;
		S_AXI_AWVALID <= 1'b0;
		S_AXI_AWADDR  <= '0;
		S_AXI_AWPROT  <= 3'b000;
		S_AXI_WVALID  <= 1'b0;
		S_AXI_WDATA   <= '0;
		S_AXI_WSTRB   <= '0;
		S_AXI_BREADY  <= 1'b1;
		S_AXI_ARVALID <= 1'b0;
		S_AXI_ARADDR  <= '0;
		S_AXI_ARPROT  <= 3'b000;
		S_AXI_RREADY  <= 1'b1;
		interrupt     <= 1'b0;
		cpu_reset     <= 1'b0;
		brk_req       <= 1'b0;
		cc_in         <= 3'b000;
		run_tests     = 0;
		fail_tests    = 0;
		run_cycles    = 0;
		clear_cycles  = 0;
		repeat (3) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
		reset_hold();
		reg_roundtrip();
		halt_release();
		step_and_clear();
		break_backpressure();
		$display("Tests run: %0d, tests failed: %0d", run_tests, fail_tests);
		if (fail_tests == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== sim/tb_cpu_model.sv ====
// Behavioral CPU debug port with a register file, halt driven stall and a break request
`include "zipdbg_defines.svh"

module tb_cpu_model (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  zipdbg_pkg::dbg_cpu_ctl_t  i_ctl,
	output zipdbg_pkg::dbg_cpu_stat_t o_stat,
	input  logic                      i_brk_req,
	input  logic [2:0]                i_cc
);
	timeunit 1ns;
	timeprecision 100ps;
	import zipdbg_pkg::*;

	// Register file and port state
	logic [`ZDBG_DATA_W-1:0] regs [0:31];
	logic [`ZDBG_DATA_W-1:0] rdata;
	logic                    stall;
	logic                    brk;
	logic [2:0]              cc;

	// Runs (stalls) one cycle after halt goes low
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			stall <= 1'b0;
			brk   <= 1'b0;
			cc    <= 3'b000;
		end
		else
		begin
			stall <= !i_ctl.halt;
			cc    <= i_cc;
			// Break sticks until the CPU is reset
			if (i_ctl.reset)
				brk <= 1'b0;
			else if (i_brk_req)
				brk <= 1'b1;
		end
	end

	// Debug write lands once the CPU is quiet
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_ctl.we && !stall)
			regs[i_ctl.wreg] <= i_ctl.wdata;
		rdata <= regs[i_ctl.rreg];
	end

	assign o_stat.stall = stall;
	assign o_stat.brk   = brk;
	assign o_stat.cc    = cc;
	assign o_stat.rdata = rdata;

endmodule

// ==== source/zipaxi_dbg.sv ====
// AXI-lite debug slave top tying request decode, command control and response together
`include "zipdbg_defines.svh"

module zipaxi_dbg #(
	parameter bit START_HALTED = 1'b1
) (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_interrupt,
	input  logic                      i_cpu_reset,
	// Write address and data
	input  logic                      S_AXI_AWVALID,
	output logic                      S_AXI_AWREADY,
	input  logic [`ZDBG_ADDR_W-1:0]   S_AXI_AWADDR,
	input  logic [2:0]                S_AXI_AWPROT,
	input  logic                      S_AXI_WVALID,
	output logic                      S_AXI_WREADY,
	input  logic [`ZDBG_DATA_W-1:0]   S_AXI_WDATA,
	input  logic [`ZDBG_DATA_W/8-1:0] S_AXI_WSTRB,
	// Write response
	output logic                      S_AXI_BVALID,
	input  logic                      S_AXI_BREADY,
	output logic [1:0]                S_AXI_BRESP,
	// Read address and data
	input  logic                      S_AXI_ARVALID,
	output logic                      S_AXI_ARREADY,
	input  logic [`ZDBG_ADDR_W-1:0]   S_AXI_ARADDR,
	input  logic [2:0]                S_AXI_ARPROT,
	output logic                      S_AXI_RVALID,
	input  logic                      S_AXI_RREADY,
	output logic [`ZDBG_DATA_W-1:0]   S_AXI_RDATA,
	output logic [1:0]                S_AXI_RRESP,
	// CPU debug port
	output zipdbg_pkg::dbg_cpu_ctl_t  o_cpu_ctl,
	input  zipdbg_pkg::dbg_cpu_stat_t i_cpu_stat,
	output logic                      o_cmd_reset,
	output logic                      o_halted
);

	// Between stages
	zipdbg_pkg::dbg_wreq_t wreq;
	zipdbg_pkg::dbg_rreq_t rreq;
	logic                  wr_stall;
	logic                  bresp_free;
	logic                  rd_free;

	// PROT bits carry nothing this slave acts on
	dbg_decode u_decode (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWVALID(S_AXI_AWVALID),
		.S_AXI_AWREADY(S_AXI_AWREADY),
		.S_AXI_AWADDR (S_AXI_AWADDR),
		.S_AXI_WVALID (S_AXI_WVALID),
		.S_AXI_WREADY (S_AXI_WREADY),
		.S_AXI_WDATA  (S_AXI_WDATA),
		.S_AXI_WSTRB  (S_AXI_WSTRB),
		.S_AXI_ARVALID(S_AXI_ARVALID),
		.S_AXI_ARREADY(S_AXI_ARREADY),
		.S_AXI_ARADDR (S_AXI_ARADDR),
		.i_bresp_free (bresp_free),
		.i_rd_free    (rd_free),
		.i_wr_stall   (wr_stall),
		.o_wreq       (wreq),
		.o_rreq       (rreq)
	);

	dbg_control #(.START_HALTED(START_HALTED)) u_control (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset  (i_cpu_reset),
		.i_wreq       (wreq),
		.i_rreq       (rreq),
		.i_cpu_stat   (i_cpu_stat),
		.o_cpu_ctl    (o_cpu_ctl),
		.o_wr_stall   (wr_stall)
	);

	dbg_response u_response (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_interrupt  (i_interrupt),
		.i_wreq       (wreq),
		.i_rreq       (rreq),
		.i_cpu_ctl    (o_cpu_ctl),
		.i_cpu_stat   (i_cpu_stat),
		.S_AXI_BVALID (S_AXI_BVALID),
		.S_AXI_BREADY (S_AXI_BREADY),
		.S_AXI_BRESP  (S_AXI_BRESP),
		.S_AXI_RVALID (S_AXI_RVALID),
		.S_AXI_RREADY (S_AXI_RREADY),
		.S_AXI_RDATA  (S_AXI_RDATA),
		.S_AXI_RRESP  (S_AXI_RRESP),
		.o_bresp_free (bresp_free),
		.o_rd_free    (rd_free)
	);

	// Handy copies for the outside
	assign o_cmd_reset = o_cpu_ctl.reset;
	assign o_halted    = !i_cpu_stat.stall;

endmodule

// ==== source/dbg_response.sv ====
// Write response, read sequencer, status word and read data channel
`include "zipdbg_defines.svh"

module dbg_response (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_interrupt,
	input  zipdbg_pkg::dbg_wreq_t     i_wreq,
	input  zipdbg_pkg::dbg_rreq_t     i_rreq,
	input  zipdbg_pkg::dbg_cpu_ctl_t  i_cpu_ctl,
	input  zipdbg_pkg::dbg_cpu_stat_t i_cpu_stat,
	// B channel
	output logic                      S_AXI_BVALID,
	input  logic                      S_AXI_BREADY,
	output logic [1:0]                S_AXI_BRESP,
	// R channel
	output logic                      S_AXI_RVALID,
	input  logic                      S_AXI_RREADY,
	output logic [`ZDBG_DATA_W-1:0]   S_AXI_RDATA,
	output logic [1:0]                S_AXI_RRESP,
	// Slots free for decode
	output logic                      o_bresp_free,
	output logic                      o_rd_free
);
	import zipdbg_pkg::*;

	dbg_rd_state_e rd_state;
	dbg_status_t   status;

	//////////////////////////////
	// Write response
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			S_AXI_BVALID <= 1'b0;
		else if (i_wreq.stb)
			S_AXI_BVALID <= 1'b1;
		else if (S_AXI_BREADY)
			S_AXI_BVALID <= 1'b0;
	end

	assign S_AXI_BRESP  = 2'b00;
	assign o_bresp_free = !S_AXI_BVALID || S_AXI_BREADY;

	//////////////////////////////
	// Status word
	//////////////////////////////

	always_comb
	begin
		status        = '0;
		status.reset  = i_cpu_ctl.reset;
		status.irq_lo = i_interrupt;
		// Not stalled counts as halted
		status.halted = !i_cpu_stat.stall;
		status.halt   = i_cpu_ctl.halt;
		status.cc     = i_cpu_stat.cc;
		status.brk    = i_cpu_stat.brk;
		status.irq_hi = i_interrupt;
	end

	//////////////////////////////
	// Read sequencer
	//////////////////////////////

	// Register reads spend one cycle in RD_CPU for the CPU's data
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_state <= RD_IDLE;
		else if (i_rreq.stb)
			rd_state <= (i_rreq.op == ROP_REG) ? RD_CPU : RD_DONE;
		else if (rd_state == RD_CPU)
			rd_state <= RD_DONE;
		else if ((rd_state == RD_DONE) && S_AXI_RREADY)
			rd_state <= RD_IDLE;
	end

	// Data only moves when a new beat is loaded
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_rreq.stb && (i_rreq.op == ROP_STATUS))
			S_AXI_RDATA <= status;
		else if (rd_state == RD_CPU)
			S_AXI_RDATA <= i_cpu_stat.rdata;
	end

	assign S_AXI_RVALID = (rd_state == RD_DONE);
	assign S_AXI_RRESP  = 2'b00;
	// Back to back once the current beat leaves
	assign o_rd_free = (rd_state == RD_IDLE) || ((rd_state == RD_DONE) && S_AXI_RREADY);

	// Beat stays put until the master takes it
	a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(S_AXI_RVALID && !S_AXI_RREADY) |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
		else $error("RVALID dropped or RDATA moved before RREADY");

endmodule

// ==== source/dbg_control.sv ====
// Halt, reset, step and clear-cache commands, reset hold and CPU register write staging
`include "zipdbg_defines.svh"

module dbg_control #(
	parameter bit START_HALTED = 1'b1
) (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_cpu_reset,
	input  zipdbg_pkg::dbg_wreq_t     i_wreq,
	input  zipdbg_pkg::dbg_rreq_t     i_rreq,
	input  zipdbg_pkg::dbg_cpu_stat_t i_cpu_stat,
	output zipdbg_pkg::dbg_cpu_ctl_t  o_cpu_ctl,
	output logic                      o_wr_stall
);
	import zipdbg_pkg::*;

	localparam int HOLD_W = $clog2(`ZDBG_RESET_HOLD);

	// Decoded write strobes
	logic                    cmd_wr;
	logic                    hi_wr;
	logic                    reg_wr;
	logic                    start_reset;
	logic                    release_halt;
	// Command state
	logic [HOLD_W-1:0]       hold_cnt;
	logic                    cmd_reset;
	logic                    cmd_halt;
	logic                    cmd_step;
	logic                    cmd_clear;
	// Staged register write
	logic                    dbg_we;
	logic [`ZDBG_REG_W-1:0]  dbg_wreg;
	logic [`ZDBG_DATA_W-1:0] dbg_wdata;

	assign cmd_wr = i_wreq.stb && (i_wreq.op == WOP_CMD);
	assign reg_wr = i_wreq.stb && (i_wreq.op == WOP_REG);
	// Halt, step and clear live in byte 1
	assign hi_wr  = cmd_wr && i_wreq.strb[1];

	// Register write still waiting on the CPU
	assign o_wr_stall = dbg_we && i_cpu_stat.stall;

	//////////////////////////////
	// CPU reset and hold
	//////////////////////////////

	// External pulse, break when running free, or reset bit written
	assign start_reset = i_cpu_reset
			|| (i_cpu_stat.brk && !START_HALTED)
			|| (cmd_wr && i_wreq.strb[0] && i_wreq.data[`ZDBG_RESET_BIT]);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || start_reset)
		begin
			hold_cnt  <= HOLD_W'(`ZDBG_RESET_HOLD - 1);
			cmd_reset <= 1'b1;
		end
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
		else
			cmd_reset <= 1'b0;
	end

	//////////////////////////////
	// Halt
	//////////////////////////////

	// Only lets go of a quiet CPU with no register write in flight
	assign release_halt = hi_wr && !i_cpu_stat.stall && !dbg_we
			&& (!i_wreq.data[`ZDBG_HALT_BIT] || i_wreq.data[`ZDBG_STEP_BIT]);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			cmd_halt <= START_HALTED;
		else if (cmd_reset && START_HALTED)
			cmd_halt <= 1'b1;
		else
		begin
			if (release_halt)
				cmd_halt <= 1'b0;
			// Any of these wins over a release
			if (hi_wr && i_wreq.data[`ZDBG_HALT_BIT] && !i_wreq.data[`ZDBG_STEP_BIT])
				cmd_halt <= 1'b1;
			if (reg_wr)
				cmd_halt <= 1'b1;
			// Step is over
			if (cmd_step)
				cmd_halt <= 1'b1;
			if (hi_wr && i_wreq.data[`ZDBG_CLEAR_BIT])
				cmd_halt <= 1'b1;
			if (i_cpu_stat.brk && START_HALTED)
				cmd_halt <= 1'b1;
		end
	end

	//////////////////////////////
	// Step and clear cache
	//////////////////////////////

	// One cycle of run, gone once the CPU moves
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || cmd_reset)
			cmd_step <= 1'b0;
		else if (hi_wr && i_wreq.data[`ZDBG_STEP_BIT])
			cmd_step <= 1'b1;
		else if (!i_cpu_stat.stall)
			cmd_step <= 1'b0;
	end

	// Needs halt alongside, done once halted
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || cmd_reset)
			cmd_clear <= 1'b0;
		else if (hi_wr && i_wreq.data[`ZDBG_CLEAR_BIT] && i_wreq.data[`ZDBG_HALT_BIT])
			cmd_clear <= 1'b1;
		else if (cmd_halt && !i_cpu_stat.stall)
			cmd_clear <= 1'b0;
	end

	//////////////////////////////
	// Register write staging
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			dbg_we <= 1'b0;
		else if (!o_wr_stall)
			dbg_we <= reg_wr;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_wr_stall && reg_wr)
		begin
			dbg_wreg  <= i_wreq.widx;
			dbg_wdata <= i_wreq.data;
		end
	end

	// Read index goes out in the accept cycle
	always_comb
	begin
		o_cpu_ctl.halt        = cmd_halt;
		o_cpu_ctl.reset       = cmd_reset;
		o_cpu_ctl.clear_cache = cmd_clear;
		o_cpu_ctl.we          = dbg_we;
		o_cpu_ctl.wreg        = dbg_wreg;
		o_cpu_ctl.wdata       = dbg_wdata;
		o_cpu_ctl.rreg        = i_rreq.ridx;
	end

	// No new register write while the staged one is stalled
	a_we_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_wr_stall |-> !reg_wr)
		else $error("register write accepted under CPU stall");

endmodule

// ==== source/dbg_decode.sv ====
// AW, W and AR skid buffers, address decode and request acceptance strobes
`include "zipdbg_defines.svh"

module dbg_decode (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	// Write address
	input  logic                      S_AXI_AWVALID,
	output logic                      S_AXI_AWREADY,
	input  logic [`ZDBG_ADDR_W-1:0]   S_AXI_AWADDR,
	// Write data
	input  logic                      S_AXI_WVALID,
	output logic                      S_AXI_WREADY,
	input  logic [`ZDBG_DATA_W-1:0]   S_AXI_WDATA,
	input  logic [`ZDBG_DATA_W/8-1:0] S_AXI_WSTRB,
	// Read address
	input  logic                      S_AXI_ARVALID,
	output logic                      S_AXI_ARREADY,
	input  logic [`ZDBG_ADDR_W-1:0]   S_AXI_ARADDR,
	// Back-pressure from control and response
	input  logic                      i_bresp_free,
	input  logic                      i_rd_free,
	input  logic                      i_wr_stall,
	output zipdbg_pkg::dbg_wreq_t     o_wreq,
	output zipdbg_pkg::dbg_rreq_t     o_rreq
);
	import zipdbg_pkg::*;

	// Word address and data+strobe widths
	localparam int WA_W = `ZDBG_ADDR_W - `ZDBG_LSB;
	localparam int WD_W = `ZDBG_DATA_W + `ZDBG_DATA_W/8;

	logic            aw_valid;
	logic            w_valid;
	logic            ar_valid;
	logic [WA_W-1:0] aw_word;
	logic [WA_W-1:0] ar_word;
	logic [WD_W-1:0] w_beat;
	logic            wr_accept;
	logic            rd_accept;
	dbg_wop_e        wr_op;

	//////////////////////////////
	// Channel skid buffers
	//////////////////////////////

	// Byte offset bits dropped on the way in
	dbg_skidbuffer #(.DW(WA_W)) u_awskd (
		.i_clk    (S_AXI_ACLK),
		.i_reset_n(S_AXI_ARESETN),
		.i_valid  (S_AXI_AWVALID),
		.o_ready  (S_AXI_AWREADY),
		.i_data   (S_AXI_AWADDR[`ZDBG_ADDR_W-1:`ZDBG_LSB]),
		.o_valid  (aw_valid),
		.i_ready  (wr_accept),
		.o_data   (aw_word)
	);

	// Data with strobes in the low nibble
	dbg_skidbuffer #(.DW(WD_W)) u_wskd (
		.i_clk    (S_AXI_ACLK),
		.i_reset_n(S_AXI_ARESETN),
		.i_valid  (S_AXI_WVALID),
		.o_ready  (S_AXI_WREADY),
		.i_data   ({S_AXI_WDATA, S_AXI_WSTRB}),
		.o_valid  (w_valid),
		.i_ready  (wr_accept),
		.o_data   (w_beat)
	);

	dbg_skidbuffer #(.DW(WA_W)) u_arskd (
		.i_clk    (S_AXI_ACLK),
		.i_reset_n(S_AXI_ARESETN),
		.i_valid  (S_AXI_ARVALID),
		.o_ready  (S_AXI_ARREADY),
		.i_data   (S_AXI_ARADDR[`ZDBG_ADDR_W-1:`ZDBG_LSB]),
		.o_valid  (ar_valid),
		.i_ready  (rd_accept),
		.o_data   (ar_word)
	);

	//////////////////////////////
	// Classify and accept
	//////////////////////////////

	// No strobes means nothing to do, just acknowledge
	always_comb
	begin
		if (w_beat[`ZDBG_DATA_W/8-1:0] == '0)
			wr_op = WOP_NONE;
		else if (aw_word[`ZDBG_SPACE_BIT])
			wr_op = WOP_REG;
		else
			wr_op = WOP_CMD;
	end

	// Register writes wait for the staged one to drain
	assign wr_accept = aw_valid && w_valid && i_bresp_free
			&& !((wr_op == WOP_REG) && i_wr_stall);

	assign rd_accept = ar_valid && i_rd_free;

	always_comb
	begin
		o_wreq.stb  = wr_accept;
		o_wreq.op   = wr_op;
		o_wreq.widx = aw_word[`ZDBG_REG_W-1:0];
		o_wreq.data = w_beat[WD_W-1 -: `ZDBG_DATA_W];
		o_wreq.strb = w_beat[`ZDBG_DATA_W/8-1:0];
		o_rreq.stb  = rd_accept;
		o_rreq.op   = aw_or_status(ar_word[`ZDBG_SPACE_BIT]);
		o_rreq.ridx = ar_word[`ZDBG_REG_W-1:0];
	end

	// Space bit to read opcode
	function automatic dbg_rop_e aw_or_status(input logic space);
		return space ? ROP_REG : ROP_STATUS;
	endfunction

	// Strobed write carries a known opcode
	a_wr_opcode: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_wreq.stb |-> !$isunknown(o_wreq.op))
		else $error("write strobe with invalid opcode");

	a_rd_opcode: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_rreq.stb |-> !$isunknown(o_rreq.op))
		else $error("read strobe with invalid opcode");

endmodule

// ==== source/dbg_skidbuffer.sv ====
// One-entry skid buffer between two valid/ready channels
module dbg_skidbuffer #(
	parameter int DW = 8
) (
	input  logic          i_clk,
	input  logic          i_reset_n,
	// Upstream side
	input  logic          i_valid,
	output logic          o_ready,
	input  logic [DW-1:0] i_data,
	// Downstream side
	output logic          o_valid,
	input  logic          i_ready,
	output logic [DW-1:0] o_data
);

	// Holding slot
	logic          r_valid;
	logic [DW-1:0] r_data;

	//////////////////////////////
	// Slot occupancy
	//////////////////////////////

	// Fill when a beat arrives and downstream refuses it
	always_ff @(posedge i_clk)
	begin
		if (!i_reset_n)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture the bus whenever the slot is free
	always_ff @(posedge i_clk)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////

	// Ready comes straight off a flop
	assign o_ready = !r_valid;

	// Held beat goes out first
	assign o_valid = i_valid || r_valid;
	assign o_data  = r_valid ? r_data : i_data;

endmodule

// ==== source/zipdbg_pkg.sv ====
// Debug request, CPU port and status word types plus opcode and state enums
`include "zipdbg_defines.svh"

package zipdbg_pkg;

	// Write and read opcodes
	typedef enum logic [1:0] {
		WOP_NONE = 2'd0,
		WOP_REG  = 2'd1,
		WOP_CMD  = 2'd2
	} dbg_wop_e;

	typedef enum logic {
		ROP_STATUS = 1'b0,
		ROP_REG    = 1'b1
	} dbg_rop_e;

	// Accepted write, one cycle strobe
	typedef struct packed {
		logic                      stb;
		dbg_wop_e                  op;
		logic [`ZDBG_REG_W-1:0]    widx;
		logic [`ZDBG_DATA_W-1:0]   data;
		logic [`ZDBG_DATA_W/8-1:0] strb;
	} dbg_wreq_t;

	// Accepted read, one cycle strobe
	typedef struct packed {
		logic                   stb;
		dbg_rop_e               op;
		logic [`ZDBG_REG_W-1:0] ridx;
	} dbg_rreq_t;

	// Wrapper toward the CPU debug port
	typedef struct packed {
		logic                    halt;
		logic                    reset;
		logic                    clear_cache;
		logic                    we;
		logic [`ZDBG_REG_W-1:0]  wreg;
		logic [`ZDBG_DATA_W-1:0] wdata;
		logic [`ZDBG_REG_W-1:0]  rreg;
	} dbg_cpu_ctl_t;

	// CPU debug port back to the wrapper
	typedef struct packed {
		logic                    stall;
		logic                    brk;
		logic [2:0]              cc;
		logic [`ZDBG_DATA_W-1:0] rdata;
	} dbg_cpu_stat_t;

	// Control/status word, MSB first
	typedef struct packed {
		logic [14:0] zero_hi;
		logic        irq_hi;
		logic        brk;
		logic [2:0]  cc;
		logic        zero_11;
		logic        halt;
		logic        halted;
		logic        zero_8;
		logic        irq_lo;
		logic        reset;
		logic [5:0]  zero_lo;
	} dbg_status_t;

	// Read sequencer
	typedef enum logic [1:0] {
		RD_IDLE = 2'd0,
		RD_CPU  = 2'd1,
		RD_DONE = 2'd2
	} dbg_rd_state_e;

endpackage

// ==== source/zipdbg_defines.svh ====
// Debug bus widths, command bit positions and CPU reset hold length
`ifndef ZIPDBG_DEFINES_SVH
`define ZIPDBG_DEFINES_SVH

// Debug bus geometry
`define ZDBG_ADDR_W      8
`define ZDBG_DATA_W      32
`define ZDBG_LSB         2
`define ZDBG_REG_W       5

// Word address bit that picks CPU register space
`define ZDBG_SPACE_BIT   5

// Command word bits
`define ZDBG_RESET_BIT   6
`define ZDBG_STEP_BIT    8
`define ZDBG_HALT_BIT    10
`define ZDBG_CLEAR_BIT   11

// Cycles the CPU stays in reset
`define ZDBG_RESET_HOLD  10

`endif
